//--- compile.f
hw/ppu_pkg.sv
hw/ppu_reg_if.sv
hw/ppu_mem.sv
hw/video_timing.sv
hw/ppu_bg_render.sv
hw/ppu_top.sv
verif/tb_ppu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the PPU testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_ppu_top -f compile.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

//--- verif/tb_ppu_top.sv
// Testbench for ppu_top on a 48x20 pixel frame with PIX_DIV 2
// Pixel checks place x and y from blank_n, hs and vs, so a frame must start with vs low
module tb_ppu_top import ppu_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_ACTIVE     = 32;
	localparam int H_TOTAL      = 48;
	localparam int H_SYNC_START = 36;
	localparam int H_SYNC_LEN   = 8;
	localparam int V_ACTIVE     = 16;
	localparam int V_TOTAL      = 20;
	localparam int V_SYNC_START = 17;
	localparam int V_SYNC_LEN   = 1;
	localparam int PIX_DIV      = 2;
	localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * PIX_DIV;
	localparam int NMI_CLKS   = (V_TOTAL - 1 - V_ACTIVE) * H_TOTAL * PIX_DIV;	// vblank length
	localparam int MAX_CYCLES = 10 * FRAME_CLKS + 4000;	// About 9 frames of waits plus bus phases

	logic       clk = 1'b0;
	logic       arst_n;
	cpu_bus_t   cpu;
	byte_t      rdata;
	logic       nmi;
	video_out_t video;
	logic       pixel_clk;

	byte_t      m_vram [16384];	// Model of VRAM
	pal_idx_t   m_pal [32];
	byte_t      m_ctrl = '0;
	byte_t      m_mask = '0;
	byte_t      m_buf = '0;	// Model of the DATA read buffer
	vram_addr_t m_addr = '0;
	logic       m_tog = 1'b0;
	logic       cpu_free = 1'b1;	// CPU may reach memory
	int         n_err = 0;
	int         n_other = 0;
	int         cycles = 0;
	int         n_pix = 0;
	int         n_strobe = 0;	// Pixel strobes since reset
	int         px = 0;
	int         py = 0;
	logic       strobe_q = 1'b0;
	logic       hs_q = 1'b1;
	logic       line_act = 1'b0;
	logic       arm = 1'b0;	// Pixel compare enabled

	ppu_top #(.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .H_SYNC_START(H_SYNC_START),
		.H_SYNC_LEN(H_SYNC_LEN), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
		.V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN), .PIX_DIV(PIX_DIV))
		dut0 (.clk, .arst_n, .cpu, .rdata, .nmi, .video, .pixel_clk);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors: %0d value mismatches, %0d other failures", n_err, n_other + 1);
			$display("Something failed");
			$finish;
		end
	end

	task automatic chk_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			n_err++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic chk_rgb(input string name, input rgb_t got, input rgb_t exp);
		if (got !== exp) begin
			n_err++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic chk_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			n_err++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	function automatic vram_addr_t addr_step();
		return m_ctrl[CTRL_INC32] ? 14'd32 : 14'd1;
	endfunction

	// Register rules of the CPU interface
	function automatic void update_model(input reg_sel_t sel, input byte_t d);
		case (sel)
			REG_CTRL: m_ctrl = d;
			REG_MASK: m_mask = d;
			REG_ADDR: begin
				if (m_tog)
					m_addr = {m_addr[13:8], d};
				else
					m_addr = {d[5:0], m_addr[7:0]};
				m_tog = !m_tog;
			end
			REG_DATA: begin
				if (cpu_free && m_addr >= PALETTE_BASE)
					m_pal[m_addr[4:0]] = d[5:0];
				else if (cpu_free)
					m_vram[m_addr] = d;
				m_addr = m_addr + addr_step();	// Steps even when dropped
			end
			default: ;
		endcase
	endfunction

	function automatic byte_t expected_data();
		byte_t e;
		if (m_addr >= PALETTE_BASE) begin
			e = {2'b00, m_pal[m_addr[4:0]]};	// Palette answers at once
		end else begin
			e = m_buf;
			m_buf = m_vram[m_addr];
		end
		m_addr = m_addr + addr_step();
		return e;
	endfunction

	function automatic rgb_t ref_pixel(input int x, input int y, input logic tsel, input logic show);
		vram_addr_t na;
		vram_addr_t pa;
		byte_t      p0;
		byte_t      p1;
		logic [1:0] pix;
		pal_idx_t   idx;
		rgb_t       c;
		na  = vram_addr_t'(32'h2000 + 32 * (y / 8) + x / 8);
		pa  = vram_addr_t'((tsel ? 4096 : 0) + 16 * int'(m_vram[na]) + y % 8);
		p0  = m_vram[pa] << (x % 8);
		p1  = m_vram[pa + 14'd8] << (x % 8);
		pix = show ? {p1[7], p0[7]} : 2'b00;
		idx = m_pal[{3'b000, pix}];
		c.r = {4{idx[1:0]}};	// Two bits times 0x55
		c.g = {4{idx[3:2]}};
		c.b = {4{idx[5:4]}};
		return c;
	endfunction

	task automatic cpu_write(input reg_sel_t sel, input byte_t d);
		@(negedge clk);
		cpu = '{cs: 1'b1, we: 1'b1, sel: sel, wdata: d};
		@(negedge clk);
		cpu = '0;
		update_model(sel, d);
	endtask

	task automatic cpu_read(input reg_sel_t sel, output byte_t d);
		@(negedge clk);
		cpu = '{cs: 1'b1, we: 1'b0, sel: sel, wdata: 8'h00};
		#10;
		d = rdata;	// Mid cycle, before the access edge
		@(negedge clk);
		cpu = '0;
	endtask

	task automatic set_addr(input vram_addr_t a);
		cpu_write(REG_ADDR, {2'b00, a[13:8]});
		cpu_write(REG_ADDR, a[7:0]);
	endtask

	task automatic data_readback();
		byte_t got;
		byte_t exp;
		cpu_read(REG_DATA, got);
		exp = expected_data();
		chk_byte("rdata", got, exp);
	endtask

	task automatic status_check(input logic vbl);
		byte_t got;
		cpu_read(REG_STATUS, got);
		m_tog = 1'b0;
		chk_byte("rdata(STATUS)", got, {vbl, 7'd0});
	endtask

	// Sync and blank against the frame position counted from reset
	task automatic sync_check();
		int pos;
		int hp;
		int vp;
		pos = n_strobe - 1;	// Output shows the pixel before the last strobe
		n_strobe++;
		if (pos >= 0) begin
			hp = pos % H_TOTAL;
			vp = (pos / H_TOTAL) % V_TOTAL;
			chk_bit("video.hs", video.hs,
				!(hp >= H_SYNC_START && hp < H_SYNC_START + H_SYNC_LEN));
			chk_bit("video.vs", video.vs,
				!(vp >= V_SYNC_START && vp < V_SYNC_START + V_SYNC_LEN));
			chk_bit("video.blank_n", video.blank_n, hp < H_ACTIVE && vp < V_ACTIVE);
		end
	endtask

	task automatic next_vsync();
		@(negedge clk);
		while (video.vs !== 1'b1)
			@(negedge clk);
		while (video.vs !== 1'b0)
			@(negedge clk);
	endtask

	task automatic nmi_rise();
		@(negedge clk);
		while (nmi !== 1'b0)
			@(negedge clk);
		while (nmi !== 1'b1)
			@(negedge clk);
	endtask

	// Pixel tracker and compare, one step per pixel strobe
	always @(negedge clk) begin
		if (strobe_q && arst_n) begin
			sync_check();
			if (!video.vs) begin
				py = 0;
				line_act = 1'b0;
			end else if (hs_q && !video.hs && line_act) begin
				py++;
				line_act = 1'b0;
			end
			hs_q = video.hs;
			if (video.blank_n) begin
				if (arm) begin
					chk_rgb($sformatf("video.rgb(%0d,%0d)", px, py), video.rgb,
						ref_pixel(px, py, m_ctrl[CTRL_BG_TABLE], m_mask[MASK_SHOW_BG]));
					n_pix++;
				end
				px++;
				line_act = 1'b1;
			end else begin
				if (arm)
					chk_rgb("video.rgb(blank)", video.rgb, '0);
				px = 0;
			end
		end
		strobe_q = pixel_clk;
	end

	initial begin
		vram_addr_t p2_addr [64];
		logic       p2_inc [64];
		vram_addr_t a;
		int         n;
		void'($urandom(88));
		arst_n = 1'b0;
		cpu    = '0;
		for (int i = 0; i < 32; i++)
			m_pal[i] = '0;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;

		chk_bit("nmi", nmi, 1'b0);
		chk_bit("video.blank_n", video.blank_n, 1'b0);
		status_check(1'b0);	// Still on line 0
		next_vsync();
		status_check(1'b1);
		status_check(1'b0);

		for (int i = 0; i < 64; i++) begin
			p2_addr[i] = vram_addr_t'($urandom % 32'h3E00);	// Stays below the palette
			p2_inc[i]  = i[0];
			cpu_write(REG_CTRL, p2_inc[i] ? 8'h04 : 8'h00);
			set_addr(p2_addr[i]);
			cpu_write(REG_DATA, byte_t'($urandom));
			cpu_write(REG_DATA, byte_t'($urandom));	// Next read buffer content
		end
		for (int i = 0; i < 64; i++) begin
			cpu_write(REG_CTRL, p2_inc[i] ? 8'h04 : 8'h00);
			set_addr(p2_addr[i]);
			data_readback();	// Stale buffer
			data_readback();
		end

		cpu_write(REG_CTRL, 8'h00);
		set_addr(PALETTE_BASE);
		for (int i = 0; i < 32; i++)
			cpu_write(REG_DATA, byte_t'($urandom));
		set_addr(PALETTE_BASE);
		for (int i = 0; i < 32; i++)
			data_readback();

		cpu_write(REG_CTRL, 8'h80);
		nmi_rise();
		n = 0;
		while (nmi === 1'b1) begin
			n++;
			@(negedge clk);
		end
		if (n != NMI_CLKS) begin
			n_other++;
			$display("nmi stayed high for %0d cycles instead of %0d", n, NMI_CLKS);
		end
		nmi_rise();
		status_check(1'b1);
		status_check(1'b0);
		chk_bit("nmi", nmi, 1'b0);
		cpu_write(REG_CTRL, 8'h00);

		// Two rows of tiles, 16 tile numbers spread over both tables
		set_addr(14'h2000);
		for (int i = 0; i < 64; i++)
			cpu_write(REG_DATA, byte_t'(17 * ($urandom % 16)));
		for (int t = 0; t < 2; t++) begin
			for (int k = 0; k < 16; k++) begin
				set_addr(vram_addr_t'(t * 4096 + k * 17 * 16));
				for (int j = 0; j < 16; j++)
					cpu_write(REG_DATA, byte_t'($urandom));
			end
		end
		set_addr(PALETTE_BASE);
		for (int i = 0; i < 4; i++)
			cpu_write(REG_DATA, byte_t'($urandom));
		next_vsync();
		cpu_write(REG_MASK, 8'h08);
		arm = 1'b1;
		next_vsync();
		cpu_write(REG_CTRL, 8'h10);	// Second frame from pattern table 1
		next_vsync();
		arm = 1'b0;
		if (n_pix != 2 * H_ACTIVE * V_ACTIVE) begin
			n_other++;
			$display("Checked %0d active pixels instead of %0d", n_pix, 2 * H_ACTIVE * V_ACTIVE);
		end

		cpu_write(REG_CTRL, 8'h00);
		a = vram_addr_t'(32'h3000 + $urandom % 32'h0E00);
		next_vsync();
		set_addr(a);
		for (int i = 0; i < 3; i++)
			cpu_write(REG_DATA, byte_t'($urandom));
		@(negedge clk);
		while (video.blank_n !== 1'b1)
			@(negedge clk);
		cpu_free = 1'b0;
		set_addr(a);
		cpu_write(REG_DATA, ~m_vram[a]);	// Dropped, address moves to a+1
		cpu_free = 1'b1;
		next_vsync();
		data_readback();
		data_readback();
		set_addr(a);
		data_readback();
		data_readback();
		cpu_write(REG_MASK, 8'h00);

		$display("Errors: %0d value mismatches, %0d other failures", n_err, n_other);
		if (n_err == 0 && n_other == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- hw/ppu_top.sv
// PPU top level. Sync defaults follow the active and total sizes when not set
module ppu_top import ppu_pkg::*; #(
	parameter int H_ACTIVE     = 256,
	parameter int H_TOTAL      = 320,
	parameter int H_SYNC_START = H_ACTIVE + (H_TOTAL - H_ACTIVE) / 4,
	parameter int H_SYNC_LEN   = (H_TOTAL - H_ACTIVE) / 2,
	parameter int V_ACTIVE     = 240,
	parameter int V_TOTAL      = 262,
	parameter int V_SYNC_START = V_ACTIVE + 1,
	parameter int V_SYNC_LEN   = 1,
	parameter int PIX_DIV      = 4
) (
	input  logic       clk,
	input  logic       arst_n,
	input  cpu_bus_t   cpu,
	output byte_t      rdata,
	output logic       nmi,
	output video_out_t video,
	output logic       pixel_clk
);

	timing_t    timing;
	mem_req_t   req;
	logic       cpu_owns;
	logic       bg_table;
	logic       show_bg;
	byte_t      vram_rdata;
	byte_t      rnd_vdata;
	pal_idx_t   pal_rdata;
	pal_idx_t   rnd_pdata;
	vram_addr_t rnd_vaddr;
	pal_addr_t  rnd_paddr;

	ppu_reg_if reg_if0 (.clk, .arst_n, .cpu, .rdata, .timing, .req, .cpu_owns,
		.vram_rdata, .pal_rdata, .bg_table, .show_bg, .nmi);

	ppu_mem mem0 (.clk, .arst_n, .cpu_owns, .req, .vram_rdata, .pal_rdata,
		.rnd_vaddr, .rnd_paddr, .rnd_vdata, .rnd_pdata);

	video_timing #(.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .H_SYNC_START(H_SYNC_START),
		.H_SYNC_LEN(H_SYNC_LEN), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
		.V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN), .PIX_DIV(PIX_DIV))
		timing0 (.clk, .arst_n, .timing);

	ppu_bg_render #(.H_ACTIVE(H_ACTIVE), .PIX_DIV(PIX_DIV)) render0 (.clk, .arst_n,
		.timing, .show_bg, .bg_table, .rnd_vaddr, .rnd_vdata, .rnd_paddr, .rnd_pdata, .video);

	assign pixel_clk = timing.pix_en;	// One clk wide pixel strobe

endmodule

//--- hw/ppu_bg_render.sv
// Background renderer with output 2 pixel strobes behind timing. Needs PIX_DIV of 2 or more
// Pixel value 0 shows palette entry 0; no attributes, no scrolling
module ppu_bg_render import ppu_pkg::*; #(
	parameter int H_ACTIVE = 256,
	parameter int PIX_DIV  = 4
) (
	input  logic       clk,
	input  logic       arst_n,
	input  timing_t    timing,
	input  logic       show_bg,
	input  logic       bg_table,
	output vram_addr_t rnd_vaddr,
	input  byte_t      rnd_vdata,
	output pal_addr_t  rnd_paddr,
	input  pal_idx_t   rnd_pdata,
	output video_out_t video
);

	typedef enum logic [2:0] {F_IDLE, F_NAME, F_LOW, F_HIGH, F_LATCH} fetch_st_t;

	fetch_st_t  st;
	logic [4:0] f_col;	// Tile column being fetched
	coord_t     f_row;	// Pixel row being fetched
	byte_t      tile;
	byte_t      lat0;
	byte_t      lat1;
	byte_t      sh0;
	byte_t      sh1;
	logic [1:0] pix_q;
	logic       act_q;
	logic       hs_q;
	logic       vs_q;
	logic       pre_ln;	// Between vblank start and line 0
	logic       nl;
	logic       grp_start;
	logic       tile_end;

	assign grp_start = timing.pix_en && (timing.h[2:0] == 3'd0);
	assign tile_end  = timing.pix_en && (timing.h[2:0] == 3'd7);
	assign nl        = timing.h >= coord_t'(H_ACTIVE - 8);	// Next tile is on the next line

	always_comb begin
		case (st)
			F_LOW:   rnd_vaddr = {1'b0, bg_table, rnd_vdata, 1'b0, f_row[2:0]};
			F_HIGH:  rnd_vaddr = {1'b0, bg_table, tile, 1'b1, f_row[2:0]};
			default: rnd_vaddr = {4'b1000, f_row[7:3], f_col};	// Nametable at 0x2000
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st <= F_IDLE;
		end else begin
			case (st)
				F_IDLE:  st <= grp_start ? F_NAME : F_IDLE;
				F_NAME:  st <= F_LOW;
				F_LOW:   st <= F_HIGH;
				F_HIGH:  st <= F_LATCH;
				default: st <= F_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (st == F_IDLE && grp_start) begin
			f_col <= nl ? 5'd0 : timing.h[7:3] + 5'd1;
			if (!nl)
				f_row <= timing.v;
			else
				f_row <= pre_ln ? '0 : timing.v + 1'b1;
		end
		if (st == F_LOW)
			tile <= rnd_vdata;
		if (st == F_HIGH)
			lat0 <= rnd_vdata;
		if (st == F_LATCH)
			lat1 <= rnd_vdata;
	end

	assign rnd_paddr = {3'b000, pix_q};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sh0    <= '0;
			sh1    <= '0;
			pix_q  <= '0;
			act_q  <= 1'b0;
			hs_q   <= 1'b1;
			vs_q   <= 1'b1;
			pre_ln <= 1'b0;
			video  <= '{rgb: '0, hs: 1'b1, vs: 1'b1, blank_n: 1'b0};
		end else begin
			if (timing.vblank)
				pre_ln <= 1'b1;
			else if (timing.v == '0)
				pre_ln <= 1'b0;
			if (timing.pix_en) begin
				if (tile_end) begin
					sh0 <= lat0;
					sh1 <= lat1;
				end else begin
					sh0 <= sh0 << 1;
					sh1 <= sh1 << 1;
				end
				pix_q         <= show_bg ? {sh1[7], sh0[7]} : 2'b00;	// Stage 1
				act_q         <= timing.active;
				hs_q          <= timing.hs;
				vs_q          <= timing.vs;
				video.rgb     <= act_q ? index_to_rgb(rnd_pdata) : '0;	// Stage 2
				video.blank_n <= act_q;
				video.hs      <= hs_q;
				video.vs      <= vs_q;
			end
		end
	end

	// The three fetches of a tile end before the shifters take it
	a_fetch_fits: assert property (@(posedge clk) disable iff (!arst_n)
		tile_end |-> (st == F_IDLE) && (PIX_DIV >= 2))
		else $error("Tile fetch overran its 8 pixels");

endmodule

//--- hw/video_timing.sv
// Video timing counters. H_TOTAL and H_ACTIVE must be multiples of 8
// vblank covers lines V_ACTIVE to V_TOTAL-2; the last line is a pre-render line
module video_timing import ppu_pkg::*; #(
	parameter int H_ACTIVE     = 256,
	parameter int H_TOTAL      = 320,
	parameter int H_SYNC_START = 272,
	parameter int H_SYNC_LEN   = 32,
	parameter int V_ACTIVE     = 240,
	parameter int V_TOTAL      = 262,
	parameter int V_SYNC_START = 241,
	parameter int V_SYNC_LEN   = 2,
	parameter int PIX_DIV      = 4
) (
	input  logic    clk,
	input  logic    arst_n,
	output timing_t timing
);

	localparam int DW = $clog2(PIX_DIV + 1);

	logic [DW-1:0] div_cnt;
	logic          pix_en;
	coord_t        h;
	coord_t        v;

	assign pix_en = div_cnt == DW'(PIX_DIV - 1);	// Last clk of each pixel

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			h       <= '0;
			v       <= '0;
		end else begin
			div_cnt <= pix_en ? '0 : div_cnt + 1'b1;
			if (pix_en) begin
				if (h == coord_t'(H_TOTAL - 1)) begin
					h <= '0;
					v <= (v == coord_t'(V_TOTAL - 1)) ? '0 : v + 1'b1;
				end else begin
					h <= h + 1'b1;
				end
			end
		end
	end

	assign timing.pix_en = pix_en;
	assign timing.h      = h;
	assign timing.v      = v;
	assign timing.active = (h < coord_t'(H_ACTIVE)) && (v < coord_t'(V_ACTIVE));
	assign timing.vblank = (v >= coord_t'(V_ACTIVE)) && (v < coord_t'(V_TOTAL - 1));
	assign timing.hs     = !((h >= coord_t'(H_SYNC_START)) &&
		(h < coord_t'(H_SYNC_START + H_SYNC_LEN)));
	assign timing.vs     = !((v >= coord_t'(V_SYNC_START)) &&
		(v < coord_t'(V_SYNC_START + V_SYNC_LEN)));

	// Renderer prefetches tile 0 in the last 8 blank pixels of a line
	a_hblank_len: assert property (@(posedge clk)
		(H_TOTAL - H_ACTIVE >= 8) && (H_TOTAL % 8 == 0) && (H_ACTIVE % 8 == 0))
		else $error("Horizontal blank too short for the tile prefetch");

endmodule

//--- hw/ppu_mem.sv
// 16 KiB VRAM with one port shared by CPU and renderer, and a 32 entry palette
// The palette has a read port for each side; only the CPU writes it
module ppu_mem import ppu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       cpu_owns,
	input  mem_req_t   req,
	output byte_t      vram_rdata,
	output pal_idx_t   pal_rdata,
	input  vram_addr_t rnd_vaddr,
	input  pal_addr_t  rnd_paddr,
	output byte_t      rnd_vdata,
	output pal_idx_t   rnd_pdata
);

	localparam int VRAM_DEPTH = 1 << $bits(vram_addr_t);
	localparam int PAL_DEPTH  = 1 << $bits(pal_addr_t);

	byte_t      vram [VRAM_DEPTH];
	pal_idx_t   pal [PAL_DEPTH];
	vram_addr_t vaddr;
	byte_t      vram_q;
	logic       vram_we;
	logic       pal_we;

	assign vaddr   = cpu_owns ? req.vaddr : rnd_vaddr;	// Ownership mux
	assign vram_we = req.we && cpu_owns && !req.to_pal;
	assign pal_we  = req.we && cpu_owns && req.to_pal;

	always_ff @(posedge clk) begin
		if (vram_we)
			vram[vaddr] <= req.wdata;
		vram_q <= vram[vaddr];
	end

	// Same read data, whoever owns the port
	assign vram_rdata = vram_q;
	assign rnd_vdata  = vram_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < PAL_DEPTH; i++)
				pal[i] <= '0;
		end else if (pal_we) begin
			pal[req.paddr] <= req.wdata[5:0];	// Top two bits not stored
		end
	end

	always_ff @(posedge clk) begin
		pal_rdata <= pal[req.paddr];
		rnd_pdata <= pal[rnd_paddr];
	end

	// Palette writes come only from 0x3F00 to 0x3F1F, there is no mirroring
	a_pal_range: assert property (@(posedge clk) disable iff (!arst_n)
		pal_we |-> (req.vaddr[7:5] == 3'd0) && (req.paddr == req.vaddr[4:0]))
		else $error("Palette write at offset 32 or more");

endmodule

//--- hw/ppu_reg_if.sv
// CPU side registers. Palette reads are served right away, except on the cycle right after
// a DATA write, which needs one idle cycle. CTRL and MASK read back as zero
module ppu_reg_if import ppu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  cpu_bus_t cpu,
	output byte_t    rdata,
	input  timing_t  timing,
	output mem_req_t req,
	output logic     cpu_owns,
	input  byte_t    vram_rdata,
	input  pal_idx_t pal_rdata,
	output logic     bg_table,
	output logic     show_bg,
	output logic     nmi
);

	byte_t      ctrl;
	byte_t      mask;
	byte_t      rd_buf;	// DATA read buffer
	byte_t      buf_now;
	vram_addr_t addr;
	vram_addr_t addr_nxt;
	logic       w_tog;	// Second ADDR write pending
	logic       vbl_flag;
	logic       vbl_q;
	logic       buf_ld_q;	// Buffer loads from VRAM this cycle
	logic       wr_acc;
	logic       rd_acc;
	logic       data_wr;
	logic       data_rd;
	logic       stat_rd;
	logic       addr_wr;
	logic       to_pal;

	assign wr_acc  = cpu.cs && cpu.we;
	assign rd_acc  = cpu.cs && !cpu.we;
	assign data_wr = wr_acc && (cpu.sel == REG_DATA);
	assign data_rd = rd_acc && (cpu.sel == REG_DATA);
	assign stat_rd = rd_acc && (cpu.sel == REG_STATUS);
	assign addr_wr = wr_acc && (cpu.sel == REG_ADDR);
	assign to_pal  = addr >= PALETTE_BASE;

	assign show_bg  = mask[MASK_SHOW_BG];
	assign bg_table = ctrl[CTRL_BG_TABLE];
	assign cpu_owns = !show_bg || timing.vblank;	// Memory is free while not drawing
	assign nmi      = vbl_flag && ctrl[CTRL_NMI];

	// High byte first, then low byte; DATA accesses step the pointer
	always_comb begin
		addr_nxt = addr;
		if (addr_wr) begin
			if (w_tog)
				addr_nxt = {addr[13:8], cpu.wdata};
			else
				addr_nxt = {cpu.wdata[5:0], addr[7:0]};
		end else if (data_wr || data_rd) begin
			addr_nxt = addr + (ctrl[CTRL_INC32] ? 14'd32 : 14'd1);
		end
	end

	assign req.we     = data_wr && cpu_owns;	// Dropped writes still step addr
	assign req.vaddr  = addr;
	assign req.paddr  = data_wr ? addr[4:0] : addr_nxt[4:0];	// Read ahead for palette
	assign req.to_pal = to_pal;
	assign req.wdata  = cpu.wdata;

	// A read right behind another sees the byte that is just arriving
	assign buf_now = buf_ld_q ? vram_rdata : rd_buf;

	always_comb begin
		case (cpu.sel)
			REG_STATUS: rdata = {vbl_flag, 7'd0};
			REG_DATA:   rdata = (to_pal && cpu_owns) ? {2'b00, pal_rdata} : buf_now;
			default:    rdata = 8'd0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl     <= '0;
			mask     <= '0;
			addr     <= '0;
			w_tog    <= 1'b0;
			vbl_flag <= 1'b0;
			vbl_q    <= 1'b0;
			buf_ld_q <= 1'b0;
			rd_buf   <= '0;
		end else begin
			addr     <= addr_nxt;
			vbl_q    <= timing.vblank;
			buf_ld_q <= data_rd && !to_pal && cpu_owns;
			if (buf_ld_q)
				rd_buf <= vram_rdata;
			if (wr_acc && (cpu.sel == REG_CTRL))
				ctrl <= cpu.wdata;
			if (wr_acc && (cpu.sel == REG_MASK))
				mask <= cpu.wdata;
			if (stat_rd)
				w_tog <= 1'b0;	// STATUS read restarts the ADDR pair
			else if (addr_wr)
				w_tog <= !w_tog;
			if (timing.vblank && !vbl_q)
				vbl_flag <= 1'b1;	// First vblank cycle
			else if (stat_rd || !timing.vblank)
				vbl_flag <= 1'b0;
		end
	end

	// The flag outlives vblank by at most the one cycle it takes to clear
	a_flag_in_vblank: assert property (@(posedge clk) disable iff (!arst_n)
		vbl_flag |-> timing.vblank || vbl_q)
		else $error("vblank flag set outside vertical blank");

endmodule

//--- hw/ppu_pkg.sv
// Shared types for the reduced PPU. Background only, no attribute tables or mirroring
// Palette index to colour is a fixed 2-bit-per-channel rule
package ppu_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [13:0] vram_addr_t;
	typedef logic [4:0]  pal_addr_t;
	typedef logic [5:0]  pal_idx_t;
	typedef logic [9:0]  coord_t;
	typedef logic [2:0]  reg_sel_t;

	localparam reg_sel_t REG_CTRL   = 3'd0;
	localparam reg_sel_t REG_MASK   = 3'd1;
	localparam reg_sel_t REG_STATUS = 3'd2;
	localparam reg_sel_t REG_ADDR   = 3'd6;
	localparam reg_sel_t REG_DATA   = 3'd7;

	localparam int CTRL_INC32    = 2;	// Step 32 instead of 1
	localparam int CTRL_BG_TABLE = 4;	// Pattern table select
	localparam int CTRL_NMI      = 7;
	localparam int MASK_SHOW_BG  = 3;

	localparam vram_addr_t PALETTE_BASE = 14'h3F00;

	typedef struct packed {
		byte_t r;
		byte_t g;
		byte_t b;
	} rgb_t;

	typedef struct packed {
		rgb_t rgb;
		logic hs;	// Active low
		logic vs;	// Active low
		logic blank_n;
	} video_out_t;

	typedef struct packed {
		logic     cs;
		logic     we;
		reg_sel_t sel;
		byte_t    wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic       we;
		vram_addr_t vaddr;
		pal_addr_t  paddr;
		logic       to_pal;
		byte_t      wdata;
	} mem_req_t;

	typedef struct packed {
		logic   pix_en;
		coord_t h;
		coord_t v;
		logic   active;
		logic   vblank;
		logic   hs;
		logic   vs;
	} timing_t;

	function automatic rgb_t index_to_rgb(input pal_idx_t idx);
		rgb_t c;
		c.r = {6'd0, idx[1:0]} * 8'h55;
		c.g = {6'd0, idx[3:2]} * 8'h55;
		c.b = {6'd0, idx[5:4]} * 8'h55;
		return c;
	endfunction

endpackage
